// ==== rt_pkg.sv ====
`default_nettype none

package rt_pkg;

	// Screen geometry, shrunk for simulation
	localparam int SCREEN_W = 16;
	localparam int SCREEN_H = 12;
	localparam int NUM_RAYS = SCREEN_W * SCREEN_H;

	// Pixel coordinate and frame buffer address widths
	localparam int COORD_W = 4;
	localparam int ADDR_W = 8;

	// Pixel counter in the frame buffer handler
	localparam int PIX_CNT_W = $clog2(NUM_RAYS);

	// Cycles from ray_valid to pb_we
	localparam int SHADE_DEPTH = 2;

	// Pixel buffer sizing
	localparam int PB_DEPTH = 8;
	localparam int PB_PTR_W = $clog2(PB_DEPTH);
	// Free count runs 0..PB_DEPTH, one bit wider than a pointer
	localparam int PB_CNT_W = $clog2(PB_DEPTH + 1);

	// Colors for pixels that miss the box
	localparam logic [23:0] BG_COLOR = 24'h202020;
	localparam logic [23:0] STRIPE_LIGHT = 24'hffffff;
	localparam logic [23:0] STRIPE_DARK = 24'h000000;

	// Red channel of a box hit
	localparam logic [7:0] HIT_RED = 8'hff;

	// Primary ray, identified by its pixel only (orthographic camera)
	typedef struct packed {
		logic [COORD_W-1:0] x;
		logic [COORD_W-1:0] y;
	} ray_t;

	// One shaded pixel on its way to the frame buffer
	typedef struct packed {
		logic [ADDR_W-1:0] addr;
		logic [23:0] color;
	} pixel_buffer_entry_t;

endpackage: rt_pkg

`default_nettype wire

// ==== ray_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module ray_gen import rt_pkg::*; (
	input logic clk,
	input logic reset,
	input logic start,
	input logic [PB_CNT_W-1:0] pb_space,
	output logic ray_valid,
	output ray_t ray
);

	logic running;
	logic [COORD_W-1:0] x_cnt;
	logic [COORD_W-1:0] y_cnt;
	logic issue;
	logic last_col;
	logic last_pixel;

	// Rays already in the shader still need room in the pixel buffer
	assign issue = running && (pb_space > PB_CNT_W'(SHADE_DEPTH));

	assign last_col = (x_cnt == COORD_W'(SCREEN_W - 1));
	assign last_pixel = last_col && (y_cnt == COORD_W'(SCREEN_H - 1));

	assign ray_valid = issue;
	assign ray.x = x_cnt;
	assign ray.y = y_cnt;

	// Raster scan, x first then y
	always_ff @(posedge clk) begin
		if (reset) begin
			running <= 1'b0;
			x_cnt <= '0;
			y_cnt <= '0;
		end else if (!running) begin
			// start only counts while idle
			if (start) begin
				running <= 1'b1;
				x_cnt <= '0;
				y_cnt <= '0;
			end
		end else if (issue) begin
			if (last_pixel) begin
				running <= 1'b0;
				x_cnt <= '0;
				y_cnt <= '0;
			end else if (last_col) begin
				x_cnt <= '0;
				y_cnt <= y_cnt + 1'b1;
			end else begin
				x_cnt <= x_cnt + 1'b1;
			end
		end
	end

endmodule: ray_gen

`default_nettype wire

// ==== aabb_shade.sv ====
`timescale 1ns/1ps
`default_nettype none

module aabb_shade import rt_pkg::*; (
	input logic clk,
	input logic reset,
	input logic ray_valid,
	input ray_t ray,
	input logic stripes_sel,
	input logic [COORD_W-1:0] xmin,
	input logic [COORD_W-1:0] xmax,
	input logic [COORD_W-1:0] ymin,
	input logic [COORD_W-1:0] ymax,
	output logic pb_we,
	output pixel_buffer_entry_t pb_data_us
);

	// Stage one
	logic s1_valid;
	logic s1_x_in;
	logic s1_y_in;
	logic s1_odd;
	ray_t s1_ray;

	// Stage two
	logic s2_valid;
	logic [23:0] s1_color;
	logic [ADDR_W-1:0] s1_addr;

	// Valid bits follow the rays through both stages
	always_ff @(posedge clk) begin
		if (reset) begin
			s1_valid <= 1'b0;
			s2_valid <= 1'b0;
		end else begin
			s1_valid <= ray_valid;
			s2_valid <= s1_valid;
		end
	end

	// Slab tests, one per axis; the ray runs along z so only x and y matter
	always_ff @(posedge clk) begin
		s1_x_in <= (ray.x >= xmin) && (ray.x <= xmax);
		s1_y_in <= (ray.y >= ymin) && (ray.y <= ymax);
		s1_odd <= ray.y[0];
		s1_ray <= ray;
	end

	// Hit gets a gradient, miss gets plain or striped background
	always_comb begin
		if (s1_x_in && s1_y_in) begin
			s1_color = {HIT_RED, s1_ray.x, 4'h0, s1_ray.y, 4'h0};
		end else if (!stripes_sel) begin
			s1_color = BG_COLOR;
		end else if (s1_odd) begin
			s1_color = STRIPE_DARK;
		end else begin
			s1_color = STRIPE_LIGHT;
		end
	end

	// Row-major frame buffer address
	assign s1_addr = ADDR_W'(s1_ray.y * SCREEN_W + s1_ray.x);

	always_ff @(posedge clk) begin
		pb_data_us.addr <= s1_addr;
		pb_data_us.color <= s1_color;
	end

	assign pb_we = s2_valid;

endmodule: aabb_shade

`default_nettype wire

// ==== fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module fifo import rt_pkg::*; #(
	parameter type T = logic [31:0]
) (
	input logic clk,
	input logic reset,
	input logic we,
	input logic re,
	input T data_in,
	output T data_out,
	output logic empty,
	output logic full,
	output logic [PB_CNT_W-1:0] space
);

	T mem [PB_DEPTH];
	logic [PB_PTR_W-1:0] rd_ptr;
	logic [PB_PTR_W-1:0] wr_ptr;
	logic [PB_CNT_W-1:0] count;
	logic do_write;
	logic do_read;

	// Drop writes to a full buffer and reads from an empty one
	assign do_write = we && !full;
	assign do_read = re && !empty;

	assign empty = (count == '0);
	assign full = (count == PB_CNT_W'(PB_DEPTH));
	assign space = PB_CNT_W'(PB_DEPTH) - count;

	// Head of the queue, valid while empty is low
	assign data_out = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (do_write) begin
			mem[wr_ptr] <= data_in;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count <= '0;
		end else begin
			if (do_write) begin
				if (wr_ptr == PB_PTR_W'(PB_DEPTH - 1)) begin
					wr_ptr <= '0;
				end else begin
					wr_ptr <= wr_ptr + 1'b1;
				end
			end
			if (do_read) begin
				if (rd_ptr == PB_PTR_W'(PB_DEPTH - 1)) begin
					rd_ptr <= '0;
				end else begin
					rd_ptr <= rd_ptr + 1'b1;
				end
			end
			// Push and pop together leave the occupancy alone
			case ({do_write, do_read})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule: fifo

`default_nettype wire

// ==== frame_buffer_handler.sv ====
`timescale 1ns/1ps
`default_nettype none

module frame_buffer_handler import rt_pkg::*; (
	input logic clk,
	input logic reset,
	input pixel_buffer_entry_t pb_data,
	input logic pb_empty,
	output logic pb_re,
	output logic [ADDR_W-1:0] sram_addr,
	output logic [23:0] sram_data,
	output logic sram_we_b,
	output logic frame_done
);

	typedef enum logic {
		IDLE,
		WRITE
	} fbh_state_t;

	fbh_state_t state;
	logic [PIX_CNT_W-1:0] pix_cnt;
	logic last_pix;

	// Pop only from idle, so each pixel takes two cycles
	assign pb_re = (state == IDLE) && !pb_empty;

	// Strobe is low for the whole WRITE cycle
	assign sram_we_b = (state != WRITE);

	assign last_pix = (pix_cnt == PIX_CNT_W'(NUM_RAYS - 1));

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= IDLE;
		end else begin
			case (state)
				IDLE: begin
					if (!pb_empty) begin
						state <= WRITE;
					end
				end
				WRITE: state <= IDLE;
				default: state <= IDLE;
			endcase
		end
	end

	// Latch the popped entry for the write cycle
	always_ff @(posedge clk) begin
		if (pb_re) begin
			sram_addr <= pb_data.addr;
			sram_data <= pb_data.color;
		end
	end

	// Pixels written so far in this frame
	always_ff @(posedge clk) begin
		if (reset) begin
			pix_cnt <= '0;
			frame_done <= 1'b0;
		end else begin
			frame_done <= 1'b0;
			if (state == WRITE) begin
				if (last_pix) begin
					pix_cnt <= '0;
					frame_done <= 1'b1;
				end else begin
					pix_cnt <= pix_cnt + 1'b1;
				end
			end
		end
	end

endmodule: frame_buffer_handler

`default_nettype wire

// ==== raytrace_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module raytrace_top import rt_pkg::*; (
	input logic clk,
	input logic reset,
	input logic start,
	input logic stripes_sel,
	input logic [COORD_W-1:0] xmin,
	input logic [COORD_W-1:0] xmax,
	input logic [COORD_W-1:0] ymin,
	input logic [COORD_W-1:0] ymax,
	output logic [ADDR_W-1:0] sram_addr,
	output logic [23:0] sram_data,
	output logic sram_we_b,
	output logic frame_done
);

	// Ray generator outputs
	logic ray_valid;
	ray_t ray;

	// Shader outputs
	logic pb_we;
	pixel_buffer_entry_t pb_data_us;

	// Pixel buffer outputs
	logic pb_empty;
	logic [PB_CNT_W-1:0] pb_space;
	pixel_buffer_entry_t pb_data_ds;

	// Frame buffer handler output
	logic pb_re;

	ray_gen rg (
		.clk(clk),
		.reset(reset),
		.start(start),
		.pb_space(pb_space),
		.ray_valid(ray_valid),
		.ray(ray)
	);

	aabb_shade shade (
		.clk(clk),
		.reset(reset),
		.ray_valid(ray_valid),
		.ray(ray),
		.stripes_sel(stripes_sel),
		.xmin(xmin),
		.xmax(xmax),
		.ymin(ymin),
		.ymax(ymax),
		.pb_we(pb_we),
		.pb_data_us(pb_data_us)
	);

	// Pixel buffer between shader and SRAM writer
	fifo #(.T(pixel_buffer_entry_t)) pb (
		.clk(clk),
		.reset(reset),
		.we(pb_we),
		.re(pb_re),
		.data_in(pb_data_us),
		.data_out(pb_data_ds),
		.empty(pb_empty),
		.full(),
		.space(pb_space)
	);

	frame_buffer_handler fbh (
		.clk(clk),
		.reset(reset),
		.pb_data(pb_data_ds),
		.pb_empty(pb_empty),
		.pb_re(pb_re),
		.sram_addr(sram_addr),
		.sram_data(sram_data),
		.sram_we_b(sram_we_b),
		.frame_done(frame_done)
	);

endmodule: raytrace_top

`default_nettype wire

// ==== raytrace_chk.sv ====
`timescale 1ns/1ps
`default_nettype none

module raytrace_chk import rt_pkg::*; (
	input logic clk,
	input logic reset,
	input logic stripes_sel,
	input logic [COORD_W-1:0] xmin,
	input logic [COORD_W-1:0] xmax,
	input logic [COORD_W-1:0] ymin,
	input logic [COORD_W-1:0] ymax,
	input logic [ADDR_W-1:0] sram_addr,
	input logic [23:0] sram_data,
	input logic sram_we_b,
	input logic frame_done,
	input logic pb_we,
	input logic pb_full
);

	logic [COORD_W-1:0] px;
	logic [COORD_W-1:0] py;
	logic [23:0] want_color;

	// Failed assertions so far
	int unsigned fail_cnt = 0;

	// Pixel position back from the row-major address
	assign px = COORD_W'(sram_addr % SCREEN_W);
	assign py = COORD_W'(sram_addr / SCREEN_W);

	always_comb begin
		if (px >= xmin && px <= xmax && py >= ymin && py <= ymax) begin
			want_color = {8'hff, 8'(px * 16), 8'(py * 16)};
		end else if (!stripes_sel) begin
			want_color = BG_COLOR;
		end else if (py % 2 == 0) begin
			want_color = STRIPE_LIGHT;
		end else begin
			want_color = STRIPE_DARK;
		end
	end

	color_rule: assert property (@(posedge clk) disable iff (reset)
		!sram_we_b |-> sram_data == want_color)
	else begin
		fail_cnt++;
		$error("pixel %0d written as %h, box rule gives %h", sram_addr, sram_data, want_color);
	end

	no_overflow: assert property (@(posedge clk) disable iff (reset) pb_we |-> !pb_full)
	else begin
		fail_cnt++;
		$error("pixel buffer written while full");
	end

	// Two cycles per pixel, never back to back
	strobe_gap: assert property (@(posedge clk) disable iff (reset) !sram_we_b |=> sram_we_b)
	else begin
		fail_cnt++;
		$error("sram_we_b low in two consecutive cycles");
	end

	done_pulse: assert property (@(posedge clk) disable iff (reset) frame_done |=> !frame_done)
	else begin
		fail_cnt++;
		$error("frame_done held longer than one cycle");
	end

endmodule: raytrace_chk

bind raytrace_top raytrace_chk chk_i (
	.clk(clk),
	.reset(reset),
	.stripes_sel(stripes_sel),
	.xmin(xmin),
	.xmax(xmax),
	.ymin(ymin),
	.ymax(ymax),
	.sram_addr(sram_addr),
	.sram_data(sram_data),
	.sram_we_b(sram_we_b),
	.frame_done(frame_done),
	.pb_we(pb_we),
	.pb_full(pb.full)
);

`default_nettype wire

// ==== tb_raytrace.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_raytrace import rt_pkg::*; ();

	localparam int RESET_CYCLES = 16;
	localparam int TIMEOUT_CYCLES = 6 * NUM_RAYS * 3 + RESET_CYCLES;
	localparam int SETTLE_CYCLES = 20;

	logic clk = 1'b0;
	logic reset;
	logic start;
	logic stripes_sel;
	logic [COORD_W-1:0] xmin;
	logic [COORD_W-1:0] xmax;
	logic [COORD_W-1:0] ymin;
	logic [COORD_W-1:0] ymax;
	logic [ADDR_W-1:0] sram_addr;
	logic [23:0] sram_data;
	logic sram_we_b;
	logic frame_done;

	// Frame capture
	logic [23:0] frame_img [NUM_RAYS];
	int unsigned addr_writes [NUM_RAYS];
	int unsigned frame_writes;
	int unsigned done_cnt;
	int unsigned writes_at_done;
	int last_addr;
	logic order_bad;

	int cycle_cnt = 0;
	int unsigned pass_cnt = 0;
	int unsigned fail_cnt = 0;
	logic [31:0] rng_state;

	raytrace_top raytrace_top_i (
		.clk(clk),
		.reset(reset),
		.start(start),
		.stripes_sel(stripes_sel),
		.xmin(xmin),
		.xmax(xmax),
		.ymin(ymin),
		.ymax(ymax),
		.sram_addr(sram_addr),
		.sram_data(sram_data),
		.sram_we_b(sram_we_b),
		.frame_done(frame_done)
	);

	always #50 clk = ~clk;

	// Record every SRAM write and frame_done
	always @(posedge clk) begin
		if (!reset && !sram_we_b) begin
			if (int'(sram_addr) < NUM_RAYS) begin
				frame_img[sram_addr] = sram_data;
				addr_writes[sram_addr]++;
			end
			if (int'(sram_addr) != last_addr + 1) begin
				order_bad = 1'b1;
			end
			last_addr = int'(sram_addr);
			frame_writes++;
		end
		if (!reset && frame_done) begin
			done_cnt++;
			writes_at_done = frame_writes;
		end
	end

	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt == TIMEOUT_CYCLES) begin
			$display("timeout after %0d cycles, frame_done never came", cycle_cnt);
			$display("sim failed");
			$finish;
		end
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] v;
		v = s;
		v = v ^ (v << 13);
		v = v ^ (v >> 17);
		v = v ^ (v << 5);
		return v;
	endfunction

	// Expected pixel color from the box rule
	function automatic logic [23:0] rule_color(input int x, input int y, input logic stripes,
			input int bx0, input int bx1, input int by0, input int by1);
		if (x >= bx0 && x <= bx1 && y >= by0 && y <= by1) begin
			return {8'hff, 8'(x * 16), 8'(y * 16)};
		end else if (!stripes) begin
			return BG_COLOR;
		end else if (y % 2 == 0) begin
			return STRIPE_LIGHT;
		end
		return STRIPE_DARK;
	endfunction

	task automatic clear_capture();
		for (int a = 0; a < NUM_RAYS; a++) begin
			addr_writes[a] = 0;
		end
		frame_writes = 0;
		done_cnt = 0;
		writes_at_done = 0;
		last_addr = -1;
		order_bad = 1'b0;
	endtask

	task automatic report_test(input string name, input int errs);
		if (errs == 0) begin
			pass_cnt++;
			$display("pass %s", name);
		end else begin
			fail_cnt++;
			$display("FAIL %s with %0d errors", name, errs);
		end
	endtask

	task automatic idle_check();
		int errs;
		errs = 0;
		clear_capture();
		repeat (SETTLE_CYCLES) @(negedge clk);
		if (frame_writes != 0) begin
			$display("error idle_after_reset: SRAM writes expected 0 actual %0d", frame_writes);
			errs++;
		end
		if (done_cnt != 0) begin
			$display("error idle_after_reset: frame_done pulses expected 0 actual %0d", done_cnt);
			errs++;
		end
		report_test("idle_after_reset", errs);
	endtask

	task automatic run_frame(input string name, input logic stripes, input int bx0,
			input int bx1, input int by0, input int by1, input logic restart_mid);
		int errs;
		int unsigned asserts_before;
		logic [23:0] want;
		errs = 0;
		asserts_before = raytrace_top_i.chk_i.fail_cnt;
		@(negedge clk);
		stripes_sel = stripes;
		xmin = COORD_W'(bx0);
		xmax = COORD_W'(bx1);
		ymin = COORD_W'(by0);
		ymax = COORD_W'(by1);
		clear_capture();
		start = 1'b1;
		@(negedge clk);
		start = 1'b0;
		if (restart_mid) begin
			while (frame_writes < NUM_RAYS / 4) @(negedge clk);
			start = 1'b1;
			@(negedge clk);
			start = 1'b0;
		end
		while (done_cnt == 0) @(negedge clk);
		// Extra writes or pulses would show up here
		repeat (SETTLE_CYCLES) @(negedge clk);
		for (int a = 0; a < NUM_RAYS; a++) begin
			want = rule_color(a % SCREEN_W, a / SCREEN_W, stripes, bx0, bx1, by0, by1);
			if (addr_writes[a] != 1) begin
				$display("error %s: writes to address %0d expected 1 actual %0d",
					name, a, addr_writes[a]);
				errs++;
			end else if (frame_img[a] !== want) begin
				$display("error %s: pixel %0d expected %h actual %h", name, a, want, frame_img[a]);
				errs++;
			end
		end
		if (frame_writes != NUM_RAYS) begin
			$display("error %s: frame writes expected %0d actual %0d",
				name, NUM_RAYS, frame_writes);
			errs++;
		end
		if (done_cnt != 1) begin
			$display("error %s: frame_done pulses expected 1 actual %0d", name, done_cnt);
			errs++;
		end
		if (writes_at_done != NUM_RAYS) begin
			$display("error %s: writes before frame_done expected %0d actual %0d",
				name, NUM_RAYS, writes_at_done);
			errs++;
		end
		if (order_bad) begin
			$display("%s: addresses were not written in ascending order", name);
			errs++;
		end
		if (raytrace_top_i.chk_i.fail_cnt != asserts_before) begin
			$display("%s: %0d assertions failed during the frame", name,
				raytrace_top_i.chk_i.fail_cnt - asserts_before);
			errs++;
		end
		report_test(name, errs);
	endtask

	initial begin
		int a;
		int b;
		int rx0;
		int rx1;
		int ry0;
		int ry1;
		logic rstripes;
		reset = 1'b1;
		start = 1'b0;
		stripes_sel = 1'b0;
		xmin = '0;
		xmax = '0;
		ymin = '0;
		ymax = '0;
		rng_state = 32'hc259_7c32;
		clear_capture();
		repeat (RESET_CYCLES) @(negedge clk);
		reset = 1'b0;

		idle_check();
		run_frame("centered_box_plain", 1'b0, 4, 11, 3, 8, 1'b0);
		run_frame("centered_box_stripes", 1'b1, 4, 11, 3, 8, 1'b0);
		run_frame("start_mid_frame", 1'b0, 4, 11, 3, 8, 1'b1);

		// Random bounds, sorted so the box is not empty
		rng_state = xorshift32(rng_state);
		a = int'(rng_state % SCREEN_W);
		rng_state = xorshift32(rng_state);
		b = int'(rng_state % SCREEN_W);
		rx0 = (a < b) ? a : b;
		rx1 = (a < b) ? b : a;
		rng_state = xorshift32(rng_state);
		a = int'(rng_state % SCREEN_H);
		rng_state = xorshift32(rng_state);
		b = int'(rng_state % SCREEN_H);
		ry0 = (a < b) ? a : b;
		ry1 = (a < b) ? b : a;
		rng_state = xorshift32(rng_state);
		rstripes = rng_state[7];
		run_frame("random_box", rstripes, rx0, rx1, ry0, ry1, 1'b0);

		// xmin above xmax, nothing can hit
		run_frame("empty_box", 1'b0, 9, 2, 3, 8, 1'b0);

		$display("tests passed %0d failed %0d, assertion failures %0d",
			pass_cnt, fail_cnt, raytrace_top_i.chk_i.fail_cnt);
		if (fail_cnt == 0 && raytrace_top_i.chk_i.fail_cnt == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule: tb_raytrace

`default_nettype wire

// ==== files.f ====
rt_pkg.sv
ray_gen.sv
aabb_shade.sv
fifo.sv
frame_buffer_handler.sv
raytrace_top.sv
raytrace_chk.sv
tb_raytrace.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the ray tracer pixel path testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --top-module tb_raytrace -f files.f

# Keep running past assertion errors so the testbench can report them
./obj_dir/Vtb_raytrace +verilator+error+limit+1000 > sim.log 2>&1 || true
cat sim.log

if grep -q "^sim passed$" sim.log; then
	exit 0
else
	echo "simulation did not pass, see sim.log"
	exit 1
fi
